// ==== tree_noc_pkg.sv ====
package tree_noc_pkg;

	localparam int FLIT_W = 34;	// 2 type bits + 32 bit body
	localparam int EP_W = 8;

	typedef enum logic [1:0] {
		FT_HEAD   = 2'b00,
		FT_BODY   = 2'b01,
		FT_TAIL   = 2'b10,
		FT_SINGLE = 2'b11	// head and tail in one flit
	} flit_type_e;

	// header view of the body word
	typedef struct packed {
		logic [EP_W-1:0] dst;
		logic [EP_W-1:0] src;
		logic [3:0] len;	// flits in the packet
		logic [11:0] spare;
	} flit_hdr_t;

	typedef union packed {
		flit_hdr_t hdr;	// head and single flits
		logic [31:0] data;	// body and tail flits
	} flit_body_u;

	typedef struct packed {
		flit_type_e ftype;
		flit_body_u body;
	} flit_t;

	function automatic logic is_head(input flit_type_e t);
		return (t == FT_HEAD) || (t == FT_SINGLE);
	endfunction

	// tail or single closes a packet
	function automatic logic is_tail(input flit_type_e t);
		return (t == FT_TAIL) || (t == FT_SINGLE);
	endfunction

	function automatic int powi(input int base, input int e);
		int r;
		r = 1;
		for (int i = 0; i < e; i++) begin
			r = r * base;
		end
		return r;
	endfunction

	// routers in all levels above level n
	function automatic int sum_powi(input int base, input int n);
		int s;
		s = 0;
		for (int i = 0; i < n; i++) begin
			s = s + powi(base, i);
		end
		return s;
	endfunction

endpackage

// ==== flit_fifo.sv ====
`timescale 1ns/1ps

module flit_fifo #(
	parameter int DEPTH = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic push,
	input  tree_noc_pkg::flit_t push_flit,
	input  logic pop,
	output tree_noc_pkg::flit_t head_flit,
	output logic not_empty
);
	import tree_noc_pkg::*;

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	flit_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic do_pop;

	// wrap at DEPTH, which need not be a power of two
	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
		if (p == AW'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign do_pop = pop && not_empty;	// pop on empty is ignored

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			count <= count + CW'(push) - CW'(do_pop);
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_flit;
	end

	assign head_flit = mem[rd_ptr];	// valid only while not_empty
	assign not_empty = (count != '0);

endmodule

// ==== rr_arbiter.sv ====
`timescale 1ns/1ps

module rr_arbiter #(
	parameter int N = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic [N-1:0] request,
	input  logic last,
	input  logic advance,
	output logic [N-1:0] grant
);

	localparam int IW = (N > 1) ? $clog2(N) : 1;

	logic locked;	// packet in progress
	logic [N-1:0] lock_gnt;
	logic [IW-1:0] last_win;
	logic [IW-1:0] win_idx;
	logic [N-1:0] rr_gnt;

	// scan starts one past the last winner
	always_comb begin
		int idx;
		logic found;
		rr_gnt = '0;
		found = 1'b0;
		for (int k = 1; k <= N; k++) begin
			idx = (int'(last_win) + k) % N;
			if (!found && request[idx]) begin
				rr_gnt[idx] = 1'b1;
				found = 1'b1;
			end
		end
	end

	assign grant = locked ? lock_gnt : rr_gnt;

	always_comb begin
		win_idx = '0;
		for (int i = 0; i < N; i++) begin
			if (grant[i])
				win_idx = IW'(i);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			locked <= 1'b0;
			lock_gnt <= '0;
			last_win <= IW'(N - 1);	// first scan begins at 0
		end else if (advance) begin
			locked <= !last;	// released by tail or single
			lock_gnt <= grant;
			last_win <= win_idx;
		end
	end

endmodule

// ==== tree_router.sv ====
`timescale 1ns/1ps

module tree_router #(
	parameter int K = 2,
	parameter int L = 3,
	parameter int LEVEL = 0,
	parameter int POS = 0,
	parameter int DEPTH = 4,
	localparam int P = (LEVEL == 0) ? K : K + 1	// root has no up port
) (
	input  logic clk,
	input  logic rst,
	input  logic [P-1:0] in_valid,
	input  logic [P-1:0][tree_noc_pkg::FLIT_W-1:0] in_flit,
	output logic [P-1:0] in_credit,
	output logic [P-1:0] out_valid,
	output logic [P-1:0][tree_noc_pkg::FLIT_W-1:0] out_flit,
	input  logic [P-1:0] out_credit
);
	import tree_noc_pkg::*;

	localparam int SPAN = powi(K, L - 1 - LEVEL);	// endpoints below this router
	localparam int SUB = SPAN / K;	// endpoints below one down port
	localparam int BASE = POS * SPAN;
	localparam int PW = (P > 1) ? $clog2(P) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	flit_t [P-1:0] head;
	logic [P-1:0] not_empty;
	logic [P-1:0] pop;
	logic [P-1:0][PW-1:0] route;

	// one staging slot per input, route is latched here
	flit_t [P-1:0] stg_flit;
	logic [P-1:0] stg_vld;
	logic [P-1:0][PW-1:0] stg_tgt;
	logic [P-1:0] stg_go;

	logic [P-1:0][P-1:0] req;	// [output][input]
	logic [P-1:0][P-1:0] gnt;
	logic [P-1:0] send;
	logic [P-1:0][CW-1:0] credits;
	flit_t [P-1:0] sel_flit;

	function automatic logic [PW-1:0] route_of(input logic [EP_W-1:0] dst);
		int d;
		d = int'(dst);
		if (LEVEL != 0 && (d < BASE || d >= BASE + SPAN))
			return PW'(K);	// outside our subtree, go up
		return PW'(((d - BASE) / SUB) % K);
	endfunction

	for (genvar i = 0; i < P; i++) begin : g_in
		flit_fifo #(
			.DEPTH(DEPTH)
		) u_fifo (
			.clk(clk),
			.rst(rst),
			.push(in_valid[i]),
			.push_flit(flit_t'(in_flit[i])),
			.pop(pop[i]),
			.head_flit(head[i]),
			.not_empty(not_empty[i])
		);

		assign route[i] = route_of(head[i].body.hdr.dst);
		assign pop[i] = not_empty[i] && (!stg_vld[i] || stg_go[i]);
	end

	assign in_credit = pop;	// every pop frees one slot upstream

	always_ff @(posedge clk) begin
		if (rst) begin
			stg_vld <= '0;
		end else begin
			for (int i = 0; i < P; i++) begin
				if (pop[i])
					stg_vld[i] <= 1'b1;
				else if (stg_go[i])
					stg_vld[i] <= 1'b0;
			end
		end
	end

	// target held from head until the tail leaves
	always_ff @(posedge clk) begin
		for (int i = 0; i < P; i++) begin
			if (pop[i]) begin
				stg_flit[i] <= head[i];
				if (is_head(head[i].ftype))
					stg_tgt[i] <= route[i];
			end
		end
	end

	always_comb begin
		for (int o = 0; o < P; o++) begin
			for (int i = 0; i < P; i++) begin
				req[o][i] = stg_vld[i] && (stg_tgt[i] == PW'(o));
			end
		end
	end

	for (genvar o = 0; o < P; o++) begin : g_out
		rr_arbiter #(
			.N(P)
		) u_arb (
			.clk(clk),
			.rst(rst),
			.request(req[o]),
			.last(is_tail(sel_flit[o].ftype)),
			.advance(send[o]),
			.grant(gnt[o])
		);
	end

	always_comb begin
		stg_go = '0;
		for (int o = 0; o < P; o++) begin
			sel_flit[o] = '0;
			for (int i = 0; i < P; i++) begin
				if (gnt[o][i])
					sel_flit[o] = stg_flit[i];
			end
			send[o] = |(gnt[o] & req[o]) && (credits[o] != '0);
			stg_go = stg_go | ({P{send[o]}} & gnt[o] & req[o]);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= '0;
			for (int o = 0; o < P; o++) begin
				credits[o] <= CW'(DEPTH);	// downstream buffer starts empty
			end
		end else begin
			out_valid <= send;
			for (int o = 0; o < P; o++) begin
				credits[o] <= credits[o] - CW'(send[o]) + CW'(out_credit[o]);
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int o = 0; o < P; o++) begin
			if (send[o])
				out_flit[o] <= sel_flit[o];
		end
	end

endmodule

// ==== tree_noc_top.sv ====
`timescale 1ns/1ps

// L counts tree levels including the endpoints, so routers sit on levels 0 to L-2
module tree_noc_top #(
	parameter int K = 2,
	parameter int L = 3,
	parameter int DEPTH = 4,
	localparam int NE = tree_noc_pkg::powi(K, L - 1)
) (
	input  logic clk,
	input  logic rst,
	input  logic [NE-1:0] in_valid,
	input  logic [NE-1:0][tree_noc_pkg::FLIT_W-1:0] in_flit,
	output logic [NE-1:0] in_credit,
	output logic [NE-1:0] out_valid,
	output logic [NE-1:0][tree_noc_pkg::FLIT_W-1:0] out_flit,
	input  logic [NE-1:0] out_credit
);
	import tree_noc_pkg::*;

	localparam int NR = sum_powi(K, L - 1);
	localparam int ROOT_ID = 0;

	// index K is the up port, unused at the root
	logic [K:0] r_in_valid [NR];
	logic [K:0][FLIT_W-1:0] r_in_flit [NR];
	logic [K:0] r_in_credit [NR];
	logic [K:0] r_out_valid [NR];
	logic [K:0][FLIT_W-1:0] r_out_flit [NR];
	logic [K:0] r_out_credit [NR];

	tree_router #(
		.K(K),
		.L(L),
		.LEVEL(0),
		.POS(0),
		.DEPTH(DEPTH)
	) u_root (
		.clk(clk),
		.rst(rst),
		.in_valid(r_in_valid[ROOT_ID][K-1:0]),
		.in_flit(r_in_flit[ROOT_ID][K-1:0]),
		.in_credit(r_in_credit[ROOT_ID][K-1:0]),
		.out_valid(r_out_valid[ROOT_ID][K-1:0]),
		.out_flit(r_out_flit[ROOT_ID][K-1:0]),
		.out_credit(r_out_credit[ROOT_ID][K-1:0])
	);

	for (genvar level = 1; level < L - 1; level++) begin : g_level
		localparam int NPOS = powi(K, level);	// routers on this level
		localparam int NTOP = sum_powi(K, level);	// routers above this level

		for (genvar pos = 0; pos < NPOS; pos++) begin : g_pos
			localparam int ID1 = NTOP + pos;
			localparam int ID2 = sum_powi(K, level - 1) + pos / K;	// parent
			localparam int PORT2 = pos % K;

			tree_router #(
				.K(K),
				.L(L),
				.LEVEL(level),
				.POS(pos),
				.DEPTH(DEPTH)
			) u_router (
				.clk(clk),
				.rst(rst),
				.in_valid(r_in_valid[ID1]),
				.in_flit(r_in_flit[ID1]),
				.in_credit(r_in_credit[ID1]),
				.out_valid(r_out_valid[ID1]),
				.out_flit(r_out_flit[ID1]),
				.out_credit(r_out_credit[ID1])
			);

			// up port of ID1 against down port PORT2 of the parent
			assign r_in_valid[ID1][K] = r_out_valid[ID2][PORT2];
			assign r_in_flit[ID1][K] = r_out_flit[ID2][PORT2];
			assign r_out_credit[ID1][K] = r_in_credit[ID2][PORT2];
			assign r_in_valid[ID2][PORT2] = r_out_valid[ID1][K];
			assign r_in_flit[ID2][PORT2] = r_out_flit[ID1][K];
			assign r_out_credit[ID2][PORT2] = r_in_credit[ID1][K];
		end
	end

	for (genvar pos = 0; pos < NE; pos++) begin : g_ep
		localparam int RID = sum_powi(K, L - 2) + pos / K;	// leaf router
		localparam int RPORT = pos % K;

		assign r_in_valid[RID][RPORT] = in_valid[pos];
		assign r_in_flit[RID][RPORT] = in_flit[pos];
		assign in_credit[pos] = r_in_credit[RID][RPORT];
		assign out_valid[pos] = r_out_valid[RID][RPORT];
		assign out_flit[pos] = r_out_flit[RID][RPORT];
		assign r_out_credit[RID][RPORT] = out_credit[pos];
	end

endmodule

// ==== tree_noc_props.sv ====
`timescale 1ns/1ps

module tree_noc_props #(
	parameter int NE = 4,
	parameter int DEPTH = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic [NE-1:0] out_valid,
	input  logic [NE-1:0][tree_noc_pkg::FLIT_W-1:0] out_flit,
	input  logic [NE-1:0] out_credit
);
	import tree_noc_pkg::*;

	for (genvar i = 0; i < NE; i++) begin : g_ep
		flit_t f;
		int credits;	// mirror of the leaf router's count toward this endpoint
		logic in_pkt;

		assign f = out_flit[i];

		always_ff @(posedge clk) begin
			if (rst) begin
				credits <= DEPTH;
				in_pkt <= 1'b0;
			end else begin
				credits <= credits - int'(out_valid[i]) + int'(out_credit[i]);
				if (out_valid[i])
					in_pkt <= (f.ftype == FT_HEAD) || (f.ftype == FT_BODY);
			end
		end

		a_reset_quiet: assert property (@(posedge clk) $past(rst) |-> !out_valid[i])
			else $error("out_valid[%0d] high during reset", i);

		// head or single only between packets
		a_head_order: assert property (@(posedge clk) disable iff (rst)
			out_valid[i] && (f.ftype == FT_HEAD || f.ftype == FT_SINGLE) |-> !in_pkt)
			else $error("head flit inside a packet on out_flit[%0d]", i);

		a_body_order: assert property (@(posedge clk) disable iff (rst)
			out_valid[i] && (f.ftype == FT_BODY || f.ftype == FT_TAIL) |-> in_pkt)
			else $error("payload flit outside a packet on out_flit[%0d]", i);

		a_credit: assert property (@(posedge clk) disable iff (rst)
			(!out_valid[i] || credits > 0) && (credits <= DEPTH))
			else $error("credit rule broken toward endpoint %0d", i);
	end

endmodule

bind tree_noc_top tree_noc_props #(
	.NE(NE),
	.DEPTH(DEPTH)
) u_props (
	.clk(clk),
	.rst(rst),
	.out_valid(out_valid),
	.out_flit(out_flit),
	.out_credit(out_credit)
);

// ==== tb_tree_noc.sv ====
`timescale 1ns/1ps

module tb_tree_noc;
	import tree_noc_pkg::*;

	localparam int K = 2;
	localparam int L = 3;
	localparam int DEPTH = 4;
	localparam int NE = K ** (L - 1);
	localparam int TIMEOUT = 5000;	// cycles allowed per wait loop

	logic clk;
	logic rst;
	logic [NE-1:0] in_valid;
	logic [NE-1:0][FLIT_W-1:0] in_flit;
	logic [NE-1:0] in_credit;
	logic [NE-1:0] out_valid;
	logic [NE-1:0][FLIT_W-1:0] out_flit;
	logic [NE-1:0] out_credit;

	logic [FLIT_W-1:0] src_q [NE][$];	// flits not yet injected
	logic [FLIT_W-1:0] exp_q [NE*NE][$];	// expected flits, index src*NE+dst
	int src_cred [NE];
	int injected [NE];
	int credits_seen [NE];
	int received [NE];
	int returned [NE];
	int owed [NE];	// credits the destination still has to give back
	int ret_delay [NE];
	int hold_left [NE];
	int cur_src [NE];
	logic [NE-1:0] open_pkt;
	logic [31:0] lfsr = 32'h0cf7_0119;

	tree_noc_top #(
		.K(K),
		.L(L),
		.DEPTH(DEPTH)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_flit(in_flit),
		.in_credit(in_credit),
		.out_valid(out_valid),
		.out_flit(out_flit),
		.out_credit(out_credit)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic abort_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("error at %0t: %s expected %h actual %h", $time, name, expected, actual);
		abort_run();
	endtask

	task automatic report_failure(input string what);
		$display("error at %0t: %s", $time, what);
		abort_run();
	endtask

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_step(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	task automatic load_stim();
		int fd;
		int n;
		int src;
		int dst;
		int len;
		int hold;
		logic [31:0] word;
		string line;
		flit_t f;
		fd = $fopen("tree_noc_stim.txt", "r");
		if (fd == 0)
			report_failure("cannot open the stimulus file tree_noc_stim.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%d %d %d %h %d", src, dst, len, word, hold);
			assert (n == 5 && src < NE && dst < NE && src != dst && len >= 1 && len <= 15)
			else report_failure({"bad line in the stimulus file: ", line});
			f = '0;
			f.ftype = (len == 1) ? FT_SINGLE : FT_HEAD;
			f.body.hdr.dst = EP_W'(dst);
			f.body.hdr.src = EP_W'(src);
			f.body.hdr.len = 4'(len);
			src_q[src].push_back(f);
			exp_q[src*NE+dst].push_back(f);
			for (int i = 1; i < len; i++) begin
				f.ftype = (i == len - 1) ? FT_TAIL : FT_BODY;
				f.body.data = word + 32'(i - 1);	// first payload flit carries word itself
				src_q[src].push_back(f);
				exp_q[src*NE+dst].push_back(f);
			end
			if (hold > hold_left[dst])
				hold_left[dst] = hold;
		end
		$fclose(fd);
	endtask

	task automatic check_quiet();
		@(negedge clk);
		assert (out_valid == '0) else report_mismatch("out_valid", 64'(0), 64'(out_valid));
		assert (in_credit == '0) else report_mismatch("in_credit", 64'(0), 64'(in_credit));
	endtask

	task automatic check_delivery(input int e, input logic [FLIT_W-1:0] word);
		flit_t f;
		int s;
		logic [FLIT_W-1:0] expected;
		f = word;
		received[e]++;
		owed[e]++;
		assert (received[e] - returned[e] <= DEPTH)
		else report_failure($sformatf("endpoint %0d got more than DEPTH flits ahead of its credits", e));
		if (f.ftype == FT_HEAD || f.ftype == FT_SINGLE) begin
			assert (!open_pkt[e])
			else report_failure($sformatf("head flit at endpoint %0d inside another packet", e));
			assert (f.body.hdr.dst == EP_W'(e))
			else report_mismatch($sformatf("out_flit[%0d] dst", e), 64'(e), 64'(f.body.hdr.dst));
			cur_src[e] = int'(f.body.hdr.src);
			open_pkt[e] = (f.ftype == FT_HEAD);
		end else begin
			assert (open_pkt[e])
			else report_failure($sformatf("payload flit at endpoint %0d without a head", e));
			open_pkt[e] = (f.ftype == FT_BODY);
		end
		s = cur_src[e];
		assert (s < NE && exp_q[s*NE+e].size() > 0)
		else report_failure($sformatf("endpoint %0d got a flit nobody sent", e));
		expected = exp_q[s*NE+e].pop_front();
		assert (word == expected)
		else report_mismatch($sformatf("out_flit[%0d]", e), 64'(expected), 64'(word));
	endtask

	// hold from the stimulus file first, then a short random delay per credit
	task automatic return_credit(input int e, output logic pulse);
		pulse = 1'b0;
		if (hold_left[e] > 0) begin
			hold_left[e]--;
		end else if (owed[e] > 0) begin
			if (ret_delay[e] > 0) begin
				ret_delay[e]--;
			end else begin
				pulse = 1'b1;
				owed[e]--;
				returned[e]++;
				ret_delay[e] = take_bits(2);
			end
		end
	endtask

	task automatic step_cycle();
		logic [NE-1:0] nv;
		logic [NE-1:0][FLIT_W-1:0] nf;
		logic [NE-1:0] nc;
		@(negedge clk);
		nv = '0;
		nf = in_flit;
		for (int e = 0; e < NE; e++) begin
			if (in_credit[e]) begin
				src_cred[e]++;
				credits_seen[e]++;
			end
			if (out_valid[e])
				check_delivery(e, out_flit[e]);
			if (src_q[e].size() > 0 && src_cred[e] > 0) begin
				nv[e] = 1'b1;
				nf[e] = src_q[e].pop_front();
				src_cred[e]--;
				injected[e]++;
			end
			return_credit(e, nc[e]);
		end
		@(posedge clk);
		in_valid <= nv;
		in_flit <= nf;
		out_credit <= nc;
	endtask

	function automatic logic all_delivered();
		for (int q = 0; q < NE * NE; q++) begin
			if (exp_q[q].size() != 0)
				return 1'b0;
		end
		return 1'b1;
	endfunction

	function automatic logic credits_home();
		for (int e = 0; e < NE; e++) begin
			if (credits_seen[e] < injected[e] || owed[e] != 0)
				return 1'b0;
		end
		return 1'b1;
	endfunction

	initial begin
		int cyc;
		rst <= 1'b1;
		in_valid <= '0;
		in_flit <= '0;
		out_credit <= '0;
		for (int e = 0; e < NE; e++) begin
			src_cred[e] = DEPTH;
			injected[e] = 0;
			credits_seen[e] = 0;
			received[e] = 0;
			returned[e] = 0;
			owed[e] = 0;
			ret_delay[e] = 0;
			hold_left[e] = 0;
			cur_src[e] = 0;
		end
		open_pkt = '0;
		load_stim();
		for (int c = 0; c < 4; c++) begin
			@(posedge clk);
			check_quiet();
		end
		@(posedge clk);
		rst <= 1'b0;	// fifth reset edge
		for (int c = 0; c < 3; c++) begin
			check_quiet();
			@(posedge clk);
		end
		cyc = 0;
		while (!all_delivered()) begin
			if (cyc == TIMEOUT)
				report_failure("timeout, not every packet reached its destination");
			step_cycle();
			cyc++;
		end
		cyc = 0;
		while (!credits_home()) begin
			if (cyc == TIMEOUT)
				report_failure("timeout, credits did not all come back");
			step_cycle();
			cyc++;
		end
		for (int e = 0; e < NE; e++) begin
			assert (credits_seen[e] == injected[e])
			else report_mismatch($sformatf("in_credit[%0d] count", e), 64'(injected[e]),
				64'(credits_seen[e]));
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== tree_noc_stim.txt ====
# src dst len first_word(hex) hold
# len in flits, 1 is a single flit; hold is cycles the destination withholds credits
0 1 1 00000000 0
0 2 1 00000000 0
0 3 1 00000000 0
1 0 1 00000000 0
1 2 1 00000000 0
1 3 1 00000000 0
2 0 1 00000000 0
2 1 1 00000000 0
2 3 1 00000000 0
3 0 1 00000000 0
3 1 1 00000000 0
3 2 1 00000000 0
# three sources converging on endpoint 2
0 2 5 a0000000 0
1 2 6 b0000000 0
3 2 4 c0000000 0
0 2 3 a0000100 0
1 2 2 b0000100 0
3 2 7 c0000100 0
# endpoint 3 withholds credits for a while
0 3 6 d0000000 150
1 3 5 e0000000 0
2 3 4 f0000000 0
2 3 1 00000000 0
3 0 7 12340000 0

// ==== verilog.f ====
tree_noc_pkg.sv
flit_fifo.sv
rr_arbiter.sv
tree_router.sv
tree_noc_top.sv
tree_noc_props.sv
tb_tree_noc.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_tree_noc
FILELIST  := verilog.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
